//--- cpuPkg.sv
// shared types for the 16-bit five-stage core
// every stage payload clears to zero for a bubble, so all control bits are active high
// opcodes outside opcodeT decode as no-ops
`default_nettype none

package cpuPkg;

	localparam int wordW = 16; // data and address width
	localparam int regIdW = 4;
	localparam int nRegs = 1 << regIdW; // sixteen registers

	typedef logic [wordW-1:0] wordT;
	typedef logic [regIdW-1:0] regIdT;

	typedef enum logic [3:0] {
		opAdd = 4'h0, // wrapping
		opSub = 4'h1,
		opXor = 4'h2,
		opLw = 4'h8, // rt <- mem[rs + off*2]
		opSw = 4'h9,
		opLlb = 4'hA, // low byte of rd
		opLhb = 4'hB, // high byte of rd
		opBr = 4'hC,
		opHlt = 4'hF
	} opcodeT;

	typedef enum logic [2:0] {
		brNe = 3'd0, // Z clear
		brEq = 3'd1,
		brGt = 3'd2, // Z and N clear
		brLt = 3'd3,
		brGe = 3'd4,
		brLe = 3'd5,
		brOvf = 3'd6,
		brAlways = 3'd7
	} brCondT;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flagsT;

	typedef struct packed {
		logic regWrite;
		logic memToReg; // writeback takes load data
		logic memRead;
		logic memWrite;
		logic aluSrc; // imm replaces operand 2
		logic byteLoad; // LLB or LHB
		flagsT flagEn; // per-flag write enable
		opcodeT aluOp;
	} ctrlT;

	typedef struct packed {
		logic valid; // an all-zero word is a real ADD
		wordT instr;
		wordT pcPlus2;
	} ifIdT;

	typedef struct packed {
		ctrlT ctrl;
		wordT srcA; // rs value
		wordT srcB; // rt, or rd for LLB/LHB/SW
		wordT imm; // already extended and shifted
		regIdT rsId;
		regIdT rtId;
		regIdT dstId;
	} idExT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memRead;
		logic memWrite;
		wordT result; // ALU result or address
		wordT storeData;
		regIdT storeId; // store source, refreshed from writeback
		regIdT dstId;
	} exMemT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		wordT result;
		wordT loadData;
		regIdT dstId;
	} memWbT;

	typedef struct packed {
		logic en; // read or write this cycle
		logic wr;
		wordT addr;
		wordT wrData;
	} dataReqT;

endpackage

`default_nettype wire

//--- stageReg.sv
// pipeline register for any stage payload
// flush and reset both load the all-zero payload, flush wins over hold
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
	parameter type payloadT = logic
) (
	input wire clk,
	input wire rstN,
	input wire hold, // keep q
	input wire flush, // load a bubble
	input wire payloadT d,
	output payloadT q
);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			q <= '0; // bubble
		end else if (flush) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

//--- fetchUnit.sv
// pc register and next-pc select
// pc starts at resetPc, no alignment check; stall and halt both freeze it
`timescale 1ns/1ps
`default_nettype none

module fetchUnit
	import cpuPkg::*;
#(
	parameter wordT resetPc = '0
) (
	input wire clk,
	input wire rstN,
	input wire stall, // hazard in decode
	input wire halt, // HLT in decode
	input wire taken,
	input wire wordT target,
	output wordT instrAddr,
	output wordT pcNext // pc+2 for IF/ID
);

	wordT pcQ;
	wordT pcPlus2;
	wordT pcD;

	assign pcPlus2 = pcQ + wordT'(2); // word-sized instructions

	always_comb begin
		if (stall || halt) begin
			pcD = pcQ; // refetch same word
		end else if (taken) begin
			pcD = target;
		end else begin
			pcD = pcPlus2;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pcQ <= resetPc;
		end else begin
			pcQ <= pcD;
		end
	end

	assign instrAddr = pcQ;
	assign pcNext = pcPlus2;

endmodule

`default_nettype wire

//--- regFile.sv
// sixteen-word register file, cleared by reset
// r0 reads zero and drops writes; a write shows on the reads in the same cycle
`timescale 1ns/1ps
`default_nettype none

module regFile
	import cpuPkg::*;
(
	input wire clk,
	input wire rstN,
	input wire regIdT rdA,
	input wire regIdT rdB,
	output wordT dataA,
	output wordT dataB,
	input wire we,
	input wire regIdT wrId,
	input wire wordT wrData
);

	wordT regs [nRegs]; // slot 0 never written

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < nRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wrId != '0) begin
			regs[wrId] <= wrData;
		end
	end

	// read port A with write bypass
	always_comb begin
		if (rdA == '0) begin
			dataA = '0;
		end else if (we && wrId == rdA) begin
			dataA = wrData; // writeback in same cycle
		end else begin
			dataA = regs[rdA];
		end
	end

	always_comb begin
		if (rdB == '0) begin
			dataB = '0;
		end else if (we && wrId == rdB) begin
			dataB = wrData;
		end else begin
			dataB = regs[rdB];
		end
	end

endmodule

`default_nettype wire

//--- decodeUnit.sv
// decode stage: control, immediates, register read, branch resolve, hazard stall
// branches resolve here on the flag register, so a branch waits while execute writes flags
// a load in execute stalls any reader of its destination for one cycle
`timescale 1ns/1ps
`default_nettype none

module decodeUnit
	import cpuPkg::*;
(
	input wire clk,
	input wire rstN,
	input wire ifIdT ifId,
	input wire flagsT flags, // current flag register
	input wire ctrlT exCtrl, // instruction in execute
	input wire regIdT exDst,
	input wire wbWe,
	input wire regIdT wbId,
	input wire wordT wbData,
	output idExT idEx,
	output logic stall,
	output logic taken,
	output wordT target,
	output logic halt
);

	opcodeT op;
	brCondT cond;
	ctrlT ctrl;
	regIdT rsId;
	regIdT rtId;
	regIdT dstId;
	logic useA; // rs really read
	logic useB; // rt/rd really read
	logic isBranch;
	logic condMet;
	logic loadUse;
	logic flagWait;
	wordT imm;
	wordT brOffset;
	wordT dataA;
	wordT dataB;

	assign op = opcodeT'(ifId.instr[15:12]);
	assign cond = brCondT'(ifId.instr[11:9]);
	assign rsId = ifId.instr[7:4];
	assign dstId = ifId.instr[11:8]; // rd or rt, same field
	assign rtId = (ctrl.byteLoad || ctrl.memWrite) ? ifId.instr[11:8] : ifId.instr[3:0];

	always_comb begin
		ctrl = '0; // unknown opcode is a no-op
		useA = 1'b0;
		useB = 1'b0;
		isBranch = 1'b0;
		halt = 1'b0;
		if (ifId.valid) begin
			case (op)
				opAdd, opSub: begin
					ctrl.regWrite = 1'b1;
					ctrl.flagEn = '1; // Z, V and N
					ctrl.aluOp = op;
					useA = 1'b1;
					useB = 1'b1;
				end
				opXor: begin
					ctrl.regWrite = 1'b1;
					ctrl.flagEn.z = 1'b1; // V and N kept
					ctrl.aluOp = op;
					useA = 1'b1;
					useB = 1'b1;
				end
				opLw: begin
					ctrl.regWrite = 1'b1;
					ctrl.memToReg = 1'b1;
					ctrl.memRead = 1'b1;
					ctrl.aluSrc = 1'b1;
					ctrl.aluOp = op;
					useA = 1'b1;
				end
				opSw: begin
					ctrl.memWrite = 1'b1;
					ctrl.aluSrc = 1'b1;
					ctrl.aluOp = op;
					useA = 1'b1;
					useB = 1'b1; // store data
				end
				opLlb, opLhb: begin
					ctrl.regWrite = 1'b1;
					ctrl.byteLoad = 1'b1;
					ctrl.aluOp = op;
					useB = 1'b1; // old rd value
				end
				opBr: isBranch = 1'b1;
				opHlt: halt = 1'b1;
				default: ctrl = '0;
			endcase
		end
	end

	// LLB/LHB byte zero-extended, memory offset sign-extended and doubled
	assign imm = ctrl.byteLoad ? wordT'(ifId.instr[7:0])
		: {{(wordW-5){ifId.instr[3]}}, ifId.instr[3:0], 1'b0};
	assign brOffset = {{(wordW-10){ifId.instr[8]}}, ifId.instr[8:0], 1'b0};
	assign target = ifId.pcPlus2 + brOffset;

	always_comb begin
		case (cond)
			brNe: condMet = !flags.z;
			brEq: condMet = flags.z;
			brGt: condMet = !flags.z && !flags.n;
			brLt: condMet = flags.n;
			brGe: condMet = flags.z || !flags.n; // gt or eq
			brLe: condMet = flags.z || flags.n;
			brOvf: condMet = flags.v;
			brAlways: condMet = 1'b1;
			default: condMet = 1'b0;
		endcase
	end

	assign loadUse = exCtrl.memRead && exDst != '0
		&& ((useA && exDst == rsId) || (useB && exDst == rtId));
	assign flagWait = isBranch && exCtrl.flagEn != '0; // flags land at end of execute
	assign stall = loadUse || flagWait;
	assign taken = isBranch && condMet && !stall;

	regFile i_regFile (
		.clk,
		.rstN,
		.rdA(rsId),
		.rdB(rtId),
		.dataA,
		.dataB,
		.we(wbWe),
		.wrId(wbId),
		.wrData(wbData)
	);

	always_comb begin
		idEx = '0; // bubble on stall or redirect
		if (!stall && !taken) begin
			idEx.ctrl = ctrl;
			idEx.srcA = dataA;
			idEx.srcB = dataB;
			idEx.imm = imm;
			idEx.rsId = rsId;
			idEx.rtId = rtId;
			idEx.dstId = dstId;
		end
	end

endmodule

`default_nettype wire

//--- executeUnit.sv
// execute stage: operand forwarding, ALU and the Z/V/N flag register
// memory-stage result has priority over writeback; r0 is never forwarded
// memory-stage forward assumes no load there, which the load-use stall guarantees
`timescale 1ns/1ps
`default_nettype none

module executeUnit
	import cpuPkg::*;
(
	input wire clk,
	input wire rstN,
	input wire idExT idEx,
	input wire exMemT memFwd, // instruction in memory stage
	input wire wbWe,
	input wire regIdT wbId,
	input wire wordT wbData,
	output exMemT exMem,
	output flagsT flags
);

	wordT fwdA;
	wordT fwdB;
	wordT opA;
	wordT opB;
	wordT sum;
	wordT diff;
	wordT result;
	logic ovfAdd;
	logic ovfSub;
	flagsT aluFlags;
	flagsT flagsQ;

	always_comb begin
		fwdA = idEx.srcA;
		if (idEx.rsId != '0 && memFwd.regWrite && memFwd.dstId == idEx.rsId) begin
			fwdA = memFwd.result;
		end else if (idEx.rsId != '0 && wbWe && wbId == idEx.rsId) begin
			fwdA = wbData;
		end
	end

	always_comb begin
		fwdB = idEx.srcB;
		if (idEx.rtId != '0 && memFwd.regWrite && memFwd.dstId == idEx.rtId) begin
			fwdB = memFwd.result;
		end else if (idEx.rtId != '0 && wbWe && wbId == idEx.rtId) begin
			fwdB = wbData;
		end
	end

	assign opA = idEx.ctrl.byteLoad ? idEx.imm : fwdA; // byte to merge
	assign opB = idEx.ctrl.aluSrc ? idEx.imm : fwdB; // mem offset

	assign sum = opA + opB; // wraps
	assign diff = opA - opB;
	assign ovfAdd = (opA[wordW-1] == opB[wordW-1]) && (sum[wordW-1] != opA[wordW-1]);
	assign ovfSub = (opA[wordW-1] != opB[wordW-1]) && (diff[wordW-1] != opA[wordW-1]);

	always_comb begin
		case (idEx.ctrl.aluOp)
			opAdd, opLw, opSw: result = sum; // address sum for memory ops
			opSub: result = diff;
			opXor: result = opA ^ opB;
			opLlb: result = {opB[wordW-1:8], opA[7:0]};
			opLhb: result = {opA[7:0], opB[7:0]};
			default: result = '0;
		endcase
	end

	assign aluFlags.z = (result == '0);
	assign aluFlags.v = (idEx.ctrl.aluOp == opSub) ? ovfSub : ovfAdd;
	assign aluFlags.n = result[wordW-1];

	// each flag written only when enabled
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			flagsQ <= '0;
		end else begin
			if (idEx.ctrl.flagEn.z) begin
				flagsQ.z <= aluFlags.z;
			end
			if (idEx.ctrl.flagEn.v) begin
				flagsQ.v <= aluFlags.v;
			end
			if (idEx.ctrl.flagEn.n) begin
				flagsQ.n <= aluFlags.n;
			end
		end
	end

	assign flags = flagsQ;

	always_comb begin
		exMem.regWrite = idEx.ctrl.regWrite;
		exMem.memToReg = idEx.ctrl.memToReg;
		exMem.memRead = idEx.ctrl.memRead;
		exMem.memWrite = idEx.ctrl.memWrite;
		exMem.result = result;
		exMem.storeData = fwdB; // forwarded rd for SW
		exMem.storeId = idEx.rtId;
		exMem.dstId = idEx.dstId;
	end

endmodule

`default_nettype wire

//--- cpu.sv
// top of the five-stage core; instruction and data memories sit outside
// both ports answer in the same cycle, a data write lands at the next rising edge
// no back-pressure, so the only stalls are load-use and branch-behind-flag-write
`timescale 1ns/1ps
`default_nettype none

module cpu
	import cpuPkg::*;
#(
	parameter wordT resetPc = '0
) (
	input wire clk,
	input wire rstN,
	output wordT instrAddr,
	input wire wordT instr,
	output dataReqT dataReq,
	input wire wordT rdData,
	output logic hlt,
	output wordT pc
);

	ifIdT ifIdD;
	ifIdT ifIdQ;
	idExT idExD;
	idExT idExQ;
	exMemT exMemD;
	exMemT exMemQ;
	memWbT memWbD;
	memWbT memWbQ;
	wordT pcNext;
	wordT target;
	wordT storeData;
	wordT wbData; // writeback value
	logic stall;
	logic taken;
	logic halt;
	flagsT flags;

	fetchUnit #(.resetPc(resetPc)) i_fetch (
		.clk, .rstN, .stall, .halt, .taken, .target, .instrAddr, .pcNext
	);

	always_comb begin
		ifIdD.valid = 1'b1;
		ifIdD.instr = instr;
		ifIdD.pcPlus2 = pcNext;
	end

	stageReg #(.payloadT(ifIdT)) i_ifId (
		.clk, .rstN, .hold(stall || halt), .flush(taken), .d(ifIdD), .q(ifIdQ)
	);

	decodeUnit i_decode (
		.clk, .rstN, .ifId(ifIdQ), .flags,
		.exCtrl(idExQ.ctrl), .exDst(idExQ.dstId),
		.wbWe(memWbQ.regWrite), .wbId(memWbQ.dstId), .wbData,
		.idEx(idExD), .stall, .taken, .target, .halt
	);

	// bubbles come from decode itself
	stageReg #(.payloadT(idExT)) i_idEx (
		.clk, .rstN, .hold(1'b0), .flush(1'b0), .d(idExD), .q(idExQ)
	);

	executeUnit i_execute (
		.clk, .rstN, .idEx(idExQ), .memFwd(exMemQ),
		.wbWe(memWbQ.regWrite), .wbId(memWbQ.dstId), .wbData,
		.exMem(exMemD), .flags
	);

	stageReg #(.payloadT(exMemT)) i_exMem (
		.clk, .rstN, .hold(1'b0), .flush(1'b0), .d(exMemD), .q(exMemQ)
	);

	// store data refreshed when writeback targets the store source
	assign storeData = (memWbQ.regWrite && memWbQ.dstId != '0
		&& memWbQ.dstId == exMemQ.storeId) ? wbData : exMemQ.storeData;

	always_comb begin
		dataReq.en = exMemQ.memRead || exMemQ.memWrite;
		dataReq.wr = exMemQ.memWrite;
		dataReq.addr = exMemQ.result;
		dataReq.wrData = storeData;
		memWbD.regWrite = exMemQ.regWrite;
		memWbD.memToReg = exMemQ.memToReg;
		memWbD.result = exMemQ.result;
		memWbD.loadData = rdData; // same-cycle read
		memWbD.dstId = exMemQ.dstId;
	end

	stageReg #(.payloadT(memWbT)) i_memWb (
		.clk, .rstN, .hold(1'b0), .flush(1'b0), .d(memWbD), .q(memWbQ)
	);

	assign wbData = memWbQ.memToReg ? memWbQ.loadData : memWbQ.result;
	assign hlt = halt; // HLT stays frozen in decode
	assign pc = instrAddr;

endmodule

`default_nettype wire

//--- cpu_assert.sv
// port checks bound into every cpu instance
// pc must hold and writes must stop once hlt has been high for three cycles
`timescale 1ns/1ps
`default_nettype none

module cpu_assert
	import cpuPkg::*;
(
	input wire clk,
	input wire rstN,
	input wire hlt,
	input wire wordT pc,
	input wire dataReqT dataReq
);

	// halt is sticky
	hltSticky: assert property (@(posedge clk) disable iff (!rstN) hlt |=> hlt)
		else $error("hlt fell after it was raised");

	pcFrozen: assert property (@(posedge clk) disable iff (!rstN)
		hlt && $past(hlt, 3) |-> $stable(pc))
		else $error("pc moved while halted");

	// word accesses only
	addrEven: assert property (@(posedge clk) disable iff (!rstN)
		dataReq.en |-> !dataReq.addr[0])
		else $error("data access to an odd address");

	// nothing older than HLT is left to store
	noWriteHalted: assert property (@(posedge clk) disable iff (!rstN)
		hlt && $past(hlt, 3) |-> !dataReq.wr)
		else $error("data write after the pipeline drained");

endmodule

bind cpu cpu_assert i_cpuAssert (
	.clk(clk), .rstN(rstN), .hlt(hlt), .pc(pc), .dataReq(dataReq)
);

`default_nettype wire

//--- tb.sv
// testbench for cpu that builds one program and predicts its stores with a sequential model
// and checks every data write in order as it happens
// both memories answer on the falling edge; unwritten data words read an address pattern
`timescale 1ns/1ps
`default_nettype none

module tb
	import cpuPkg::*;
();

	localparam int nTests = 6;
	localparam int memWords = 256; // instruction words

	logic clk = 1'b0;
	logic rstN;
	wordT instr = '0;
	wordT rdData = '0;
	wordT instrAddr;
	dataReqT dataReq;
	logic hlt;
	wordT pc;

	wordT imem [memWords];
	wordT dmem [wordT]; // written words only
	wordT modelMem [wordT];
	wordT expAddr [$]; // predicted stores in program order
	wordT expData [$];
	int expTest [$];
	string testName [nTests] = '{"arith", "loadUse", "storeFwd", "branch", "flags", "halt"};
	int testStart [nTests]; // first instruction of each test
	logic testBad [nTests] = '{default: 1'b0};
	wordT rngState = 16'd60; // seed
	wordT base; // even data base in r13
	wordT haltPc; // word after HLT
	logic pcBad = 1'b0;
	int progLen = 0;
	int seen = 0;
	int passed = 0;
	int failed = 0;
	int stray = 0;
	int cycles = 0;
	int cycleLimit = 1000000;

	cpu #(.resetPc(16'h0000)) i_cpu (
		.clk, .rstN, .instrAddr, .instr, .dataReq, .rdData, .hlt, .pc
	);

	always #2 clk = ~clk; // 4 ns period

	function automatic wordT nextRand();
		rngState = rngState ^ (rngState << 7); // xorshift 7/9/8
		rngState = rngState ^ (rngState >> 9);
		rngState = rngState ^ (rngState << 8);
		return rngState;
	endfunction

	function automatic wordT fillWord(wordT a);
		return (a ^ 16'hA5C3) + {a[7:0], a[15:8]}; // every address bit matters
	endfunction

	// op with rd rs rt fields for ALU and rt rs offset for memory
	function automatic wordT threeField(opcodeT op, int f2, int f1, int f0);
		return {op, 4'(f2), 4'(f1), 4'(f0)};
	endfunction

	function automatic wordT byteImm(opcodeT op, int rd, logic [7:0] imm);
		return {op, 4'(rd), imm};
	endfunction

	function automatic wordT condBranch(brCondT cond, int off);
		return {opBr, cond, 9'(off)};
	endfunction

	task automatic put(wordT w);
		imem[progLen] = w;
		progLen++;
	endtask

	task automatic setReg(int r, wordT v);
		put(byteImm(opLlb, r, v[7:0]));
		put(byteImm(opLhb, r, v[15:8])); // LHB takes LLB result by forwarding
	endtask

	task automatic buildProgram();
		wordT a;
		wordT b;
		for (int i = 0; i < memWords; i++) begin
			imem[i] = {opHlt, 12'h000}; // unused words halt
		end
		a = nextRand();
		b = nextRand();
		base = nextRand() & 16'hFFFE;
		testStart[0] = progLen;
		setReg(1, a);
		setReg(2, b);
		setReg(13, base);
		setReg(10, 16'h0001);
		setReg(11, 16'h0002);
		setReg(12, 16'h7FFF); // largest positive
		put(threeField(opAdd, 3, 1, 2));
		put(threeField(opSub, 4, 3, 1)); // uses result one ahead
		put(threeField(opXor, 5, 4, 2));
		put(threeField(opSw, 3, 13, 0));
		put(threeField(opSw, 4, 13, 1));
		put(threeField(opSw, 5, 13, 2));
		testStart[1] = progLen;
		put(threeField(opLw, 6, 13, 1));
		put(threeField(opAdd, 7, 6, 1)); // load-use
		put(threeField(opSw, 7, 13, 3));
		put(threeField(opLw, 6, 13, -8)); // unwritten word
		put(threeField(opSw, 6, 13, -7));
		testStart[2] = progLen;
		put(threeField(opXor, 8, 1, 2));
		put(threeField(opSw, 8, 13, 4));
		put(byteImm(opLlb, 8, 8'h3C));
		put(threeField(opSw, 8, 13, 5));
		testStart[3] = progLen;
		for (int s = 0; s < 4; s++) begin
			for (int c = 0; c < 8; c++) begin
				put(byteImm(opLlb, 14, 8'(s * 8 + c))); // marker
				case (s)
					0: put(threeField(opSub, 9, 10, 10)); // zero
					1: put(threeField(opSub, 9, 10, 11)); // negative
					2: put(threeField(opSub, 9, 11, 10)); // positive
					default: put(threeField(opAdd, 9, 12, 10)); // overflow
				endcase
				put(condBranch(brCondT'(3'(c)), 1)); // taken skips the store
				put(threeField(opSw, 14, 13, c));
			end
		end
		testStart[4] = progLen;
		put(byteImm(opLlb, 14, 8'h50));
		put(threeField(opAdd, 9, 12, 10)); // sets V
		put(condBranch(brOvf, 1));
		put(threeField(opSw, 14, 13, 6));
		put(byteImm(opLlb, 14, 8'h51));
		put(threeField(opXor, 9, 10, 11)); // V kept
		put(condBranch(brOvf, 1));
		put(threeField(opSw, 14, 13, 7));
		put(threeField(opSw, 14, 13, -1));
		testStart[5] = progLen;
		put(threeField(opSw, 2, 13, -2));
		put({opHlt, 12'h000});
		put(threeField(opSw, 1, 13, -3)); // behind HLT so never runs
	endtask

	// sequential interpreter stepping one instruction at a time
	task automatic runModel();
		wordT r [16];
		wordT pcM;
		wordT w;
		wordT a;
		wordT b;
		wordT d;
		wordT res;
		wordT addr;
		logic z;
		logic v;
		logic n;
		logic met;
		logic done;
		int t;
		pcM = '0;
		z = 1'b0;
		v = 1'b0;
		n = 1'b0;
		met = 1'b0;
		done = 1'b0;
		for (int i = 0; i < 16; i++) begin
			r[i] = '0;
		end
		for (int step = 0; step < 1000 && !done; step++) begin
			w = imem[pcM[8:1]];
			a = r[w[7:4]];
			b = r[w[3:0]];
			d = r[w[11:8]]; // rd or store source
			addr = a + {{11{w[3]}}, w[3:0], 1'b0};
			t = 0;
			for (int k = 1; k < nTests; k++) begin
				if (int'(pcM[8:1]) >= testStart[k]) begin
					t = k;
				end
			end
			pcM = pcM + 16'd2;
			res = d; // ops without a result write back the old value
			case (w[15:12])
				opAdd: begin
					res = a + b;
					v = (a[15] == b[15]) && (res[15] != a[15]);
					n = res[15];
					z = (res == '0);
				end
				opSub: begin
					res = a - b;
					v = (a[15] != b[15]) && (res[15] != a[15]);
					n = res[15];
					z = (res == '0);
				end
				opXor: begin
					res = a ^ b;
					z = (res == '0);
				end
				opLlb: res = {d[15:8], w[7:0]};
				opLhb: res = {w[7:0], d[7:0]};
				opLw: res = modelMem.exists(addr) ? modelMem[addr] : fillWord(addr);
				opSw: begin
					modelMem[addr] = d;
					expAddr.push_back(addr);
					expData.push_back(d);
					expTest.push_back(t);
				end
				opBr: begin
					case (w[11:9])
						brNe: met = !z;
						brEq: met = z;
						brGt: met = !z && !n;
						brLt: met = n;
						brGe: met = (!z && !n) || z;
						brLe: met = n || z;
						brOvf: met = v;
						default: met = 1'b1;
					endcase
					if (met) begin
						pcM = pcM + {{6{w[8]}}, w[8:0], 1'b0};
					end
				end
				opHlt: done = 1'b1;
				default: res = d; // unused opcode
			endcase
			if (w[11:8] != 4'h0) begin
				r[w[11:8]] = res;
			end
		end
		haltPc = pcM; // fetch stops on the word after HLT
	endtask

	task automatic checkStore(wordT addr, wordT data);
		int t;
		logic last;
		if (seen >= expAddr.size()) begin
			$display("store of %h to %h came after all expected stores", data, addr);
			stray++;
		end else begin
			t = expTest[seen];
			assert (addr == expAddr[seen] && data == expData[seen]) else begin
				$display("Error %s: expected %h at %h, actual %h at %h", testName[t],
					expData[seen], expAddr[seen], data, addr);
				testBad[t] = 1'b1;
			end
			seen++;
			last = 1'b1;
			if (seen < expAddr.size()) begin
				last = (expTest[seen] != t);
			end
			if (last) begin
				if (testBad[t]) begin
					failed++;
				end else begin
					passed++;
				end
				$display("test %s finished, %s", testName[t], testBad[t] ? "mismatch" : "ok");
			end
		end
	endtask

	// memories answer half a cycle after the request
	always @(negedge clk) begin
		instr <= imem[instrAddr[8:1]];
		rdData <= dmem.exists(dataReq.addr) ? dmem[dataReq.addr] : fillWord(dataReq.addr);
		if (rstN && dataReq.en && dataReq.wr) begin
			checkStore(dataReq.addr, dataReq.wrData);
		end
	end

	always @(posedge clk) begin
		if (rstN && dataReq.en && dataReq.wr) begin
			dmem[dataReq.addr] = dataReq.wrData; // write lands at the edge
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("timeout after %0d cycles, the cpu never halted", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		rstN = 1'b0;
		buildProgram();
		runModel();
		cycleLimit = 16 + 4 * progLen + 20;
		repeat (16) @(negedge clk);
		rstN = 1'b1;
		while (!hlt) begin
			@(negedge clk);
		end
		repeat (8) @(negedge clk); // drain and catch late writes
		assert (pc == haltPc) else begin
			$display("Error %s: expected pc %h, actual pc %h", testName[nTests-1], haltPc, pc);
			pcBad = 1'b1;
		end
		if (seen != expAddr.size()) begin
			$display("only %0d of %0d expected stores were seen", seen, expAddr.size());
		end
		$display("tests passed %0d, failed %0d", passed, failed);
		if (failed == 0 && stray == 0 && seen == expAddr.size() && !pcBad) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
cpuPkg.sv
stageReg.sv
fetchUnit.sv
regFile.sv
decodeUnit.sv
executeUnit.sv
cpu.sv
cpu_assert.sv
tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --assert -j 0
TOP = tb
FILELIST = vlog.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
